/* include/csi_rx_defines.svh */
/*
 * CSI-2 receiver constants
 * HS sync byte, PHY settle time, deskew depth, data types and APB map
 */
`ifndef CSI_RX_DEFINES_SVH
`define CSI_RX_DEFINES_SVH

// Leader byte that opens every HS burst
`define CSI_SYNC_BYTE        8'hB8

// byte_clock cycles from reset release to PHY ready
`define CSI_SETTLE_CYCLES    16

// Entries per deskew FIFO for up to 3 cycles of lane skew
`define CSI_SKEW_DEPTH       4

// ----------------------------------------
// Data types
`define CSI_DT_FRAME_START   6'h00
`define CSI_DT_FRAME_END     6'h01
`define CSI_DT_LONG_MIN      6'h10   // This and above are long packets

// ----------------------------------------
// APB byte offsets
`define CSI_REG_CTRL         8'h00
`define CSI_REG_STATUS       8'h04
`define CSI_REG_FRAMES       8'h08
`define CSI_REG_PACKETS      8'h0C
`define CSI_REG_HEADER       8'h10

`endif

/* verilog/csi_pkg.sv */
/*
 * CSI-2 receive path types
 * Lane bytes, aligned word pairs, packet header, payload and events
 */
package csi_pkg;

   typedef logic [7:0]  csi_byte_t;
   typedef logic [15:0] csi_word_t;
   typedef logic [15:0] csi_wc_t;    // Word count in bytes

   // Raw byte from one SERDES lane
   typedef struct packed {
      logic      hs_active;
      csi_byte_t data;             // Bit 0 is earliest in time
   } csi_lane_t;

   typedef struct packed {
      logic      valid;
      csi_byte_t data;
   } csi_aligned_t;

   // Deskewed two-lane word
   typedef struct packed {
      logic      valid;
      csi_word_t data;             // Lane 0 in the low byte
      logic      burst_end;
   } csi_pair_t;

   typedef struct packed {
      logic [1:0] vc;
      logic [5:0] dt;
      csi_wc_t    wc;
      csi_byte_t  ecc;             // Stored only
   } csi_header_t;

   typedef struct packed {
      logic      valid;
      csi_word_t data;
      logic      low_only;         // High byte past the word count
      logic      first;
      logic      last;
   } csi_payload_t;

   // Single-cycle pulses
   typedef struct packed {
      logic frame_start;
      logic frame_end;
      logic long_done;
      logic header_valid;
   } csi_event_t;

endpackage

/* verilog/csi_apb_pkg.sv */
/*
 * APB register port types
 * Request and response bundles plus the counter width
 */
package csi_apb_pkg;

   typedef logic [7:0]  apb_addr_t;
   typedef logic [31:0] apb_data_t;

   typedef struct packed {
      logic      psel;
      logic      penable;
      logic      pwrite;
      apb_addr_t paddr;
      apb_data_t pwdata;
   } apb_req_t;

   typedef struct packed {
      apb_data_t prdata;
      logic      pready;           // No wait states
      logic      pslverr;          // Unmapped offset
   } apb_rsp_t;

   // Frame and packet counters
   typedef logic [15:0] csi_count_t;

endpackage

/* verilog/csi_rx_phy_clk.sv */
/*
 * Byte clock reset and PHY settle
 * Releases rst three edges after PLL lock and raises phy_ready later
 */
`include "csi_rx_defines.svh"

module csi_rx_phy_clk (
   input  logic byte_clock,
   input  logic pll_lock,
   output logic rst,               // Active high
   output logic phy_ready
);

   logic [2:0] rst_sync;
   logic [4:0] settle_cnt;

   // Asserts at once on lock loss, releases through three flops
   always_ff @(posedge byte_clock or negedge pll_lock) begin
      if (!pll_lock) begin
         rst_sync <= '1;
      end else begin
         rst_sync <= {rst_sync[1:0], 1'b0};
      end
   end

   assign rst = rst_sync[2];

   // ----------------------------------------
   // Settle time after reset release
   always_ff @(posedge byte_clock or negedge pll_lock) begin
      if (!pll_lock) begin
         settle_cnt <= '0;
         phy_ready  <= 1'b0;
      end else if (rst) begin
         settle_cnt <= '0;
         phy_ready  <= 1'b0;
      end else if (!phy_ready) begin
         settle_cnt <= settle_cnt + 5'd1;
         if (settle_cnt == 5'(`CSI_SETTLE_CYCLES - 1))
            phy_ready <= 1'b1;     // Holds until lock drops
      end
   end

endmodule

/* verilog/csi_rx_byte_align.sv */
/*
 * Lane byte aligner
 * Finds the HS sync byte at any bit offset and emits aligned bytes
 */
`include "csi_rx_defines.svh"

module csi_rx_byte_align (
   input  logic                   byte_clock,
   input  logic                   pll_lock,
   input  logic                   rst,
   input  logic                   enable,
   input  csi_pkg::csi_lane_t     lane,
   output csi_pkg::csi_aligned_t  aligned,
   output logic                   locked
);
   import csi_pkg::*;

   csi_byte_t   prev;              // Previous raw byte
   logic [15:0] window;
   logic [2:0]  offset;            // Locked bit offset
   logic        hit;
   logic [2:0]  hit_off;

   // Earlier byte in the low half
   assign window = {lane.data, prev};

   always_ff @(posedge byte_clock) begin
      prev <= lane.data;
   end

   // ----------------------------------------
   // Sync search over the eight slices
   always_comb begin
      hit     = 1'b0;
      hit_off = '0;
      for (int k = 7; k >= 0; k--) begin
         if (window[k +: 8] == `CSI_SYNC_BYTE) begin
            hit     = 1'b1;
            hit_off = 3'(k);       // Lowest offset wins
         end
      end
   end

   always_ff @(posedge byte_clock or negedge pll_lock) begin
      if (!pll_lock) begin
         locked  <= 1'b0;
         offset  <= '0;
         aligned <= '0;
      end else if (rst) begin
         locked  <= 1'b0;
         offset  <= '0;
         aligned <= '0;
      end else begin
         aligned.valid <= locked && lane.hs_active;
         aligned.data  <= window[offset +: 8];
         if (!lane.hs_active) begin
            locked <= 1'b0;        // End of burst
         end else if (!locked && enable && hit) begin
            locked <= 1'b1;
            offset <= hit_off;
         end
      end
   end

endmodule

/* verilog/csi_rx_lane_align.sv */
/*
 * Two-lane deskew
 * Per-lane FIFOs absorb skew and pop byte pairs as 16-bit words
 */
`include "csi_rx_defines.svh"

module csi_rx_lane_align (
   input  logic                  byte_clock,
   input  logic                  pll_lock,
   input  logic                  rst,
   input  csi_pkg::csi_aligned_t lane0,
   input  csi_pkg::csi_aligned_t lane1,
   input  logic                  lane0_active,
   input  logic                  lane1_active,
   output csi_pkg::csi_pair_t    pair
);
   import csi_pkg::*;

   localparam int PTR_W = $clog2(`CSI_SKEW_DEPTH);

   csi_aligned_t     lane_in [2];
   csi_byte_t        mem     [2][`CSI_SKEW_DEPTH];
   logic [PTR_W-1:0] wr_ptr  [2];
   logic [PTR_W-1:0] rd_ptr  [2];
   logic [PTR_W:0]   count   [2];
   logic             pop;
   logic             idle;
   logic             last;
   logic             flush;

   assign lane_in[0] = lane0;
   assign lane_in[1] = lane1;

   assign pop  = (count[0] != '0) && (count[1] != '0);
   // Both lanes quiet and nothing more in flight
   assign idle = !lane0_active && !lane1_active && !lane0.valid && !lane1.valid;
   assign last = idle && pop && (count[0] == 1 || count[1] == 1);
   // Leftover byte on one lane is dropped too
   assign flush = idle && (last || (!pop && (count[0] != '0 || count[1] != '0)));

   always_ff @(posedge byte_clock) begin
      for (int i = 0; i < 2; i++) begin
         if (lane_in[i].valid)
            mem[i][wr_ptr[i]] <= lane_in[i].data;
      end
   end

   // ----------------------------------------
   // Pointers, fill levels and output word
   always_ff @(posedge byte_clock or negedge pll_lock) begin
      if (!pll_lock || rst) begin
         for (int i = 0; i < 2; i++) begin
            wr_ptr[i] <= '0;
            rd_ptr[i] <= '0;
            count[i]  <= '0;
         end
         pair <= '0;
      end else begin
         for (int i = 0; i < 2; i++) begin
            if (flush) begin
               wr_ptr[i] <= '0;
               rd_ptr[i] <= '0;
               count[i]  <= '0;
            end else begin
               if (lane_in[i].valid)
                  wr_ptr[i] <= wr_ptr[i] + 1'b1;
               if (pop)
                  rd_ptr[i] <= rd_ptr[i] + 1'b1;
               count[i] <= count[i] + (PTR_W+1)'(lane_in[i].valid) - (PTR_W+1)'(pop);
            end
         end
         pair.valid     <= pop;
         pair.burst_end <= last;
         if (pop)
            pair.data <= {mem[1][rd_ptr[1]], mem[0][rd_ptr[0]]};   // Lane 0 low
      end
   end

endmodule

/* verilog/csi_rx_packet_decode.sv */
/*
 * Packet decoder
 * Builds the header from two words, streams long payload, flags frames
 */
`include "csi_rx_defines.svh"

module csi_rx_packet_decode (
   input  logic                  byte_clock,
   input  logic                  pll_lock,
   input  logic                  rst,
   input  csi_pkg::csi_pair_t    pair,
   output csi_pkg::csi_payload_t payload,
   output csi_pkg::csi_event_t   events,
   output csi_pkg::csi_header_t  header
);
   import csi_pkg::*;

   typedef enum logic [2:0] {
      S_HDR0,                      // DI and WC low byte
      S_HDR1,                      // WC high byte and ECC
      S_PAYLOAD,
      S_CRC,
      S_DRAIN                      // Skip to burst end
   } state_t;

   state_t      state;
   csi_word_t   hdr_word0;
   csi_wc_t     words_left;
   logic        first_pend;
   logic        odd_wc;
   csi_header_t hdr_next;
   csi_wc_t     n_words;
   logic        is_long;

   // Header as seen with the second word on the input
   assign hdr_next = '{vc:  hdr_word0[7:6],
                       dt:  hdr_word0[5:0],
                       wc:  {pair.data[7:0], hdr_word0[15:8]},
                       ecc: pair.data[15:8]};

   assign n_words = csi_wc_t'((17'(hdr_next.wc) + 17'd1) >> 1);   // ceil(wc/2)
   assign is_long = hdr_next.dt >= `CSI_DT_LONG_MIN;

   always_ff @(posedge byte_clock or negedge pll_lock) begin
      if (!pll_lock || rst) begin
         state      <= S_HDR0;
         hdr_word0  <= '0;
         words_left <= '0;
         first_pend <= 1'b0;
         odd_wc     <= 1'b0;
         payload    <= '0;
         events     <= '0;
         header     <= '0;
      end else begin
         payload <= '0;            // Valid and pulses last one cycle
         events  <= '0;
         if (pair.valid) begin
            case (state)
               S_HDR0: begin
                  hdr_word0 <= pair.data;
                  state     <= S_HDR1;
               end
               S_HDR1: begin
                  header              <= hdr_next;
                  events.header_valid <= 1'b1;
                  if (is_long) begin
                     words_left <= n_words;
                     odd_wc     <= hdr_next.wc[0];
                     first_pend <= 1'b1;
                     if (n_words == '0) begin
                        events.long_done <= 1'b1;   // Empty long packet
                        state            <= S_CRC;
                     end else begin
                        state <= S_PAYLOAD;
                     end
                  end else begin
                     // Other short types are only recorded
                     events.frame_start <= (hdr_next.dt == `CSI_DT_FRAME_START);
                     events.frame_end   <= (hdr_next.dt == `CSI_DT_FRAME_END);
                     state              <= S_DRAIN;
                  end
               end
               // ----------------------------------------
               S_PAYLOAD: begin
                  payload.valid    <= 1'b1;
                  payload.data     <= pair.data;
                  payload.first    <= first_pend;
                  payload.last     <= (words_left == 1);
                  payload.low_only <= (words_left == 1) && odd_wc;
                  first_pend       <= 1'b0;
                  words_left       <= words_left - 1'b1;
                  if (words_left == 1) begin
                     events.long_done <= 1'b1;
                     state            <= S_CRC;
                  end
               end
               S_CRC:   state <= S_DRAIN;   // CRC word dropped
               default: ;
            endcase
            if (pair.burst_end)
               state <= S_HDR0;    // Next burst starts a new packet
         end
      end
   end

endmodule

/* verilog/csi_rx_apb_regs.sv */
/*
 * APB control and status registers
 * Enable, lane status, frame and packet counters, last header
 */
`include "csi_rx_defines.svh"

module csi_rx_apb_regs (
   input  logic                  byte_clock,
   input  logic                  pll_lock,
   input  logic                  rst,
   input  csi_apb_pkg::apb_req_t apb_req,
   output csi_apb_pkg::apb_rsp_t apb_rsp,
   input  logic                  phy_ready,
   input  logic [1:0]            locked,
   input  csi_pkg::csi_event_t   events,
   input  csi_pkg::csi_header_t  header,
   output logic                  enable
);
   import csi_apb_pkg::*;

   logic       setup;
   logic       wr_access;
   apb_data_t  rd_data;
   logic       addr_err;
   csi_count_t frames;
   csi_count_t packets;

   assign setup     = apb_req.psel && !apb_req.penable;
   assign wr_access = apb_req.psel && apb_req.penable && apb_req.pwrite;

   // ----------------------------------------
   // Read mux and decode
   always_comb begin
      rd_data  = '0;
      addr_err = 1'b0;
      case (apb_req.paddr)
         `CSI_REG_CTRL:    rd_data = {31'd0, enable};
         `CSI_REG_STATUS:  rd_data = {29'd0, locked, phy_ready};
         `CSI_REG_FRAMES:  rd_data = {16'd0, frames};
         `CSI_REG_PACKETS: rd_data = {16'd0, packets};
         `CSI_REG_HEADER:  rd_data = header;
         default:          addr_err = 1'b1;
      endcase
   end

   always_ff @(posedge byte_clock or negedge pll_lock) begin
      if (!pll_lock || rst) begin
         enable  <= 1'b1;          // Receiver on out of reset
         frames  <= '0;
         packets <= '0;
         apb_rsp <= '0;
      end else begin
         // Response registered in setup so it is ready in access
         apb_rsp.pready  <= setup;
         apb_rsp.pslverr <= setup && addr_err;
         if (setup)
            apb_rsp.prdata <= rd_data;

         if (events.frame_end)
            frames <= frames + 1'b1;
         if (events.long_done)
            packets <= packets + 1'b1;

         if (wr_access) begin
            case (apb_req.paddr)
               `CSI_REG_CTRL:    enable  <= apb_req.pwdata[0];
               `CSI_REG_FRAMES:  frames  <= '0;   // Any value clears
               `CSI_REG_PACKETS: packets <= '0;
               default: ;
            endcase
         end
      end
   end

endmodule

/* verilog/csi_rx_top.sv */
/*
 * Two-lane CSI-2 receiver, byte clock side
 * Reset and settle, byte and lane alignment, packet decode, APB registers
 */
module csi_rx_top (
   input  logic                  byte_clock,
   input  logic                  pll_lock,
   input  csi_pkg::csi_lane_t    lane_in [2],
   input  csi_apb_pkg::apb_req_t apb_req,
   output csi_apb_pkg::apb_rsp_t apb_rsp,
   output csi_pkg::csi_payload_t payload,
   output csi_pkg::csi_event_t   events
);
   import csi_pkg::*;

   logic         rst;
   logic         phy_ready;
   logic         enable;
   csi_aligned_t aligned [2];
   logic [1:0]   locked;
   csi_pair_t    pair;
   csi_header_t  header;

   csi_rx_phy_clk u_phy_clk (
      .byte_clock (byte_clock),
      .pll_lock   (pll_lock),
      .rst        (rst),
      .phy_ready  (phy_ready)
   );

   // ----------------------------------------
   // One aligner per lane
   for (genvar i = 0; i < 2; i++) begin : g_lane
      csi_rx_byte_align u_byte_align (
         .byte_clock (byte_clock),
         .pll_lock   (pll_lock),
         .rst        (rst),
         .enable     (enable),
         .lane       (lane_in[i]),
         .aligned    (aligned[i]),
         .locked     (locked[i])
      );
   end

   csi_rx_lane_align u_lane_align (
      .byte_clock   (byte_clock),
      .pll_lock     (pll_lock),
      .rst          (rst),
      .lane0        (aligned[0]),
      .lane1        (aligned[1]),
      .lane0_active (lane_in[0].hs_active),
      .lane1_active (lane_in[1].hs_active),
      .pair         (pair)
   );

   csi_rx_packet_decode u_decode (
      .byte_clock (byte_clock),
      .pll_lock   (pll_lock),
      .rst        (rst),
      .pair       (pair),
      .payload    (payload),
      .events     (events),
      .header     (header)
   );

   csi_rx_apb_regs u_regs (
      .byte_clock (byte_clock),
      .pll_lock   (pll_lock),
      .rst        (rst),
      .apb_req    (apb_req),
      .apb_rsp    (apb_rsp),
      .phy_ready  (phy_ready),
      .locked     (locked),
      .events     (events),
      .header     (header),
      .enable     (enable)
   );

endmodule

/* sim/csi_rx_tb.sv */
/*
 * CSI-2 receiver testbench
 * Serializes packets onto two skewed lanes, reads registers over APB
 * and checks payload words, events and counters
 */
`include "csi_rx_defines.svh"

module csi_rx_tb;
   import csi_pkg::*;
   import csi_apb_pkg::*;

   // Rough cycle budget per test
   localparam int RESET_CYCLES   = 80;
   localparam int LONG_CYCLES    = 100;
   localparam int SHORT_CYCLES   = 60;
   localparam int DISABLE_CYCLES = 120;
   localparam int RUN_CYCLES     = RESET_CYCLES + 13 * LONG_CYCLES + 3 * SHORT_CYCLES
                                   + DISABLE_CYCLES;

   logic         byte_clock = 1'b0;
   logic         pll_lock;
   csi_lane_t    lane_in [2];
   apb_req_t     apb_req;
   apb_rsp_t     apb_rsp;
   csi_payload_t payload;
   csi_event_t   events;

   csi_payload_t got_q[$];          // Payload words of the current packet
   int           pay_cnt   = 0;
   int           hdr_cnt   = 0;
   int           fs_cnt    = 0;
   int           fe_cnt    = 0;
   int           done_cnt  = 0;
   int           long_sent = 0;     // Long packets sent since reset

   csi_rx_top uut (
      .byte_clock (byte_clock),
      .pll_lock   (pll_lock),
      .lane_in    (lane_in),
      .apb_req    (apb_req),
      .apb_rsp    (apb_rsp),
      .payload    (payload),
      .events     (events)
   );

   always #20 byte_clock = ~byte_clock;

   // Collector samples registered outputs mid-cycle
   always @(negedge byte_clock) begin
      if (payload.valid) begin
         got_q.push_back(payload);
         pay_cnt++;
      end
      if (events.header_valid) hdr_cnt++;
      if (events.frame_start)  fs_cnt++;
      if (events.frame_end)    fe_cnt++;
      if (events.long_done)    done_cnt++;
   end

   // ----------------------------------------
   // Failure reporting and compares
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input csi_word_t exp, input csi_word_t got);
      if (got !== exp)
         abort_run($sformatf("Error at %0t: %s expected %h got %h", $time, name, exp, got));
   endtask

   task automatic check_header(input string name, input csi_header_t exp,
                               input csi_header_t got);
      if (got !== exp)
         abort_run($sformatf("Error at %0t: %s expected %h got %h", $time, name, exp, got));
   endtask

   task automatic check_count(input string name, input csi_count_t exp, input csi_count_t got);
      if (got !== exp)
         abort_run($sformatf("Error at %0t: %s expected %0d got %0d", $time, name, exp, got));
   endtask

   task automatic check_flag(input string name, input logic exp, input logic got);
      if (got !== exp)
         abort_run($sformatf("Error at %0t: %s expected %b got %b", $time, name, exp, got));
   endtask

   // ----------------------------------------
   // APB master with a setup and one access phase
   task automatic apb_transfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                               output apb_data_t rdata, output logic err);
      @(posedge byte_clock);
      apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
      @(posedge byte_clock);
      apb_req.penable <= 1'b1;
      @(negedge byte_clock);
      check_flag("apb_rsp.pready", 1'b1, apb_rsp.pready);   // No wait states
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(posedge byte_clock);
      apb_req <= '0;
   endtask

   task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata, output logic err);
      apb_transfer(1'b0, addr, '0, rdata, err);
   endtask

   task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
      apb_data_t rd;
      logic      err;
      apb_transfer(1'b1, addr, wdata, rd, err);
      check_flag("apb_rsp.pslverr", 1'b0, err);
   endtask

   // ----------------------------------------
   // Packet builder and lane serializer model
   function automatic csi_header_t random_long_header();
      csi_header_t h;
      h.vc  = 2'($urandom);
      h.dt  = 6'(`CSI_DT_LONG_MIN + $urandom % 48);
      h.wc  = csi_wc_t'(1 + $urandom % 40);
      h.ecc = 8'($urandom);
      return h;
   endfunction

   task automatic build_packet(input csi_header_t hdr, output csi_byte_t pkt[$]);
      pkt.delete();
      pkt.push_back({hdr.vc, hdr.dt});   // Data identifier
      pkt.push_back(hdr.wc[7:0]);
      pkt.push_back(hdr.wc[15:8]);
      pkt.push_back(hdr.ecc);
      if (hdr.dt >= `CSI_DT_LONG_MIN)
         repeat (hdr.wc + 2) pkt.push_back(8'($urandom));   // Payload then CRC
      if (pkt.size() % 2 != 0)
         pkt.push_back(8'h00);             // Even split over two lanes
   endtask

   // Each lane sends a zero byte, off zero bits and the sync byte ahead of its bytes LSB first
   task automatic send_burst(input csi_byte_t pkt[$], input int off0, input int off1,
                             input int skew1);
      logic [255:0] bits [2];
      csi_lane_t    drv  [2];
      int           offs [2];
      int           dly  [2];
      int           n;
      int           r;
      n    = pkt.size() / 2;
      offs = '{off0, off1};
      dly  = '{0, skew1};
      for (int l = 0; l < 2; l++) begin
         bits[l] = '0;
         bits[l][8 + offs[l] +: 8] = `CSI_SYNC_BYTE;
         for (int j = 0; j < n; j++)
            bits[l][16 + offs[l] + 8 * j +: 8] = pkt[2 * j + l];   // Lane 0 even bytes
      end
      // n + 3 raw bytes hold the whole lane before an idle gap
      for (int t = 0; t < n + 3 + skew1 + 8; t++) begin
         for (int l = 0; l < 2; l++) begin
            r = t - dly[l];
            if (r >= 0 && r < n + 3)
               drv[l] = '{hs_active: 1'b1, data: bits[l][8 * r +: 8]};
            else
               drv[l] = '0;
         end
         @(posedge byte_clock);
         lane_in[0] <= drv[0];
         lane_in[1] <= drv[1];
      end
   endtask

   task automatic wait_events(input int hdr_target, input int done_target);
      int cycles;
      cycles = 0;
      while ((hdr_cnt < hdr_target || done_cnt < done_target) && cycles < 200) begin
         @(posedge byte_clock);
         cycles++;
      end
      if (hdr_cnt < hdr_target || done_cnt < done_target)
         abort_run("Packet was not decoded within 200 cycles");
   endtask

   // Sends one packet and checks payload stream and HEADER register
   task automatic send_packet(input csi_header_t hdr, input int off0, input int off1,
                              input int skew1);
      csi_byte_t pkt[$];
      int        hdr0;
      int        done0;
      int        n_words;
      logic      is_long;
      apb_data_t rd;
      logic      err;
      is_long = (hdr.dt >= `CSI_DT_LONG_MIN);
      n_words = is_long ? (hdr.wc + 1) / 2 : 0;      // ceil(wc/2)
      build_packet(hdr, pkt);
      hdr0  = hdr_cnt;
      done0 = done_cnt;
      got_q.delete();
      send_burst(pkt, off0, off1, skew1);
      wait_events(hdr0 + 1, is_long ? done0 + 1 : done0);
      check_count("payload word count", csi_count_t'(n_words), csi_count_t'(got_q.size()));
      foreach (got_q[i]) begin
         check_word("payload.data", {pkt[5 + 2 * i], pkt[4 + 2 * i]}, got_q[i].data);
         check_flag("payload.first", i == 0, got_q[i].first);
         check_flag("payload.last", i == n_words - 1, got_q[i].last);
         check_flag("payload.low_only", (i == n_words - 1) && hdr.wc[0], got_q[i].low_only);
      end
      apb_read(`CSI_REG_HEADER, rd, err);
      check_header("HEADER", hdr, csi_header_t'(rd));
      if (is_long) long_sent++;
   endtask

   // ----------------------------------------
   // Directed tests
   task automatic check_reset_status();
      apb_data_t rd;
      logic      err;
      int        tries;
      check_flag("apb_rsp.pready", 1'b0, apb_rsp.pready);   // Still in reset
      check_flag("payload.valid", 1'b0, payload.valid);
      repeat (3) @(posedge byte_clock);   // rst release edge
      rd    = '0;
      tries = 0;
      while (!rd[0] && tries < 20) begin
         apb_read(`CSI_REG_STATUS, rd, err);
         tries++;
      end
      if (!rd[0])
         abort_run("phy_ready never rose after reset");
      check_flag("STATUS.locked[0]", 1'b0, rd[1]);
      check_flag("STATUS.locked[1]", 1'b0, rd[2]);
      check_count("payload words before phy_ready", '0, csi_count_t'(pay_cnt));
   endtask

   task automatic sweep_bit_offsets();
      for (int off = 0; off < 8; off++)
         send_packet(random_long_header(), off, off, 0);
   endtask

   task automatic deskew_lanes();
      int off0;
      int off1;
      for (int skew = 0; skew < 4; skew++) begin
         off0 = $urandom % 8;
         off1 = (off0 + 1 + $urandom % 7) % 8;   // Never equal to lane 0
         send_packet(random_long_header(), off0, off1, skew);
      end
   endtask

   task automatic count_frames();
      csi_header_t fs_hdr;
      csi_header_t fe_hdr;
      csi_header_t gen_hdr;
      int          fs0;
      int          fe0;
      apb_data_t   rd;
      logic        err;
      fs_hdr  = '{vc: 2'd0, dt: `CSI_DT_FRAME_START, wc: 16'd1, ecc: 8'h3C};
      fe_hdr  = '{vc: 2'd0, dt: `CSI_DT_FRAME_END, wc: 16'd1, ecc: 8'h2D};
      gen_hdr = '{vc: 2'd1, dt: 6'h08, wc: 16'h1234, ecc: 8'h71};   // Generic short
      fs0 = fs_cnt;
      fe0 = fe_cnt;
      send_packet(fs_hdr, 3, 5, 1);
      send_packet(random_long_header(), 2, 6, 2);
      send_packet(gen_hdr, 1, 1, 0);
      send_packet(fe_hdr, 4, 0, 3);
      check_count("frame_start pulses", csi_count_t'(fs0 + 1), csi_count_t'(fs_cnt));
      check_count("frame_end pulses", csi_count_t'(fe0 + 1), csi_count_t'(fe_cnt));
      apb_read(`CSI_REG_FRAMES, rd, err);
      check_count("FRAMES", 16'd1, rd[15:0]);
      apb_read(`CSI_REG_PACKETS, rd, err);
      check_count("PACKETS", csi_count_t'(long_sent), rd[15:0]);
   endtask

   task automatic disable_receiver();
      csi_header_t hdr;
      csi_byte_t   pkt[$];
      int          hdr0;
      apb_data_t   rd;
      logic        err;
      hdr    = random_long_header();
      hdr.wc = 16'd16;                    // Burst long enough to read STATUS inside it
      build_packet(hdr, pkt);
      apb_write(`CSI_REG_CTRL, 32'd0);
      hdr0 = hdr_cnt;
      got_q.delete();
      fork
         send_burst(pkt, 5, 2, 1);
         begin
            repeat (5) @(posedge byte_clock);   // Both lanes past their sync byte
            apb_read(`CSI_REG_STATUS, rd, err);
         end
      join
      check_flag("STATUS.locked[0]", 1'b0, rd[1]);
      check_flag("STATUS.locked[1]", 1'b0, rd[2]);
      check_count("payload words while disabled", '0, csi_count_t'(got_q.size()));
      check_count("headers while disabled", csi_count_t'(hdr0), csi_count_t'(hdr_cnt));
      apb_write(`CSI_REG_CTRL, 32'd1);
      apb_read(8'h20, rd, err);           // Unmapped offset
      check_flag("apb_rsp.pslverr", 1'b1, err);
      apb_write(`CSI_REG_FRAMES, 32'hFFFF_FFFF);
      apb_read(`CSI_REG_FRAMES, rd, err);
      check_count("FRAMES after clear", '0, rd[15:0]);
   endtask

   // ----------------------------------------
   initial begin
      repeat (2 * RUN_CYCLES) @(posedge byte_clock);
      abort_run("Watchdog expired before the tests finished");
   end

   initial begin
      void'($urandom(33972));
      pll_lock   = 1'b0;
      lane_in[0] = '0;
      lane_in[1] = '0;
      apb_req    = '0;
      repeat (3) @(posedge byte_clock);
      pll_lock <= 1'b1;
      check_reset_status();
      sweep_bit_offsets();
      deskew_lanes();
      count_frames();
      disable_receiver();
      $display("Done: no errors");
      $finish;
   end

endmodule

/* src.f */
+incdir+include
verilog/csi_pkg.sv
verilog/csi_apb_pkg.sv
verilog/csi_rx_phy_clk.sv
verilog/csi_rx_byte_align.sv
verilog/csi_rx_lane_align.sv
verilog/csi_rx_packet_decode.sv
verilog/csi_rx_apb_regs.sv
verilog/csi_rx_top.sv
sim/csi_rx_tb.sv

/* Bender.yml */
package:
  name: csi_rx

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/csi_pkg.sv
      - verilog/csi_apb_pkg.sv
      - verilog/csi_rx_phy_clk.sv
      - verilog/csi_rx_byte_align.sv
      - verilog/csi_rx_lane_align.sv
      - verilog/csi_rx_packet_decode.sv
      - verilog/csi_rx_apb_regs.sv
      - verilog/csi_rx_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/csi_rx_tb.sv
